/* hdl/julia_pkg.sv */
package julia_pkg;

	// signed Q11.11 fixed point
	localparam int WIDTH = 22;
	localparam int FRAC  = 11;
	localparam int PROD_W = 2 * WIDTH; // full product width

	// screen geometry
	localparam int COORD_BITS = 10;
	localparam int SCREEN_W   = 640;
	localparam int CENTER_X   = 320; // column at re = 0
	localparam int CENTER_Y   = 240; // row at im = 0
	localparam int MAP_SHIFT  = 3;   // one pixel is 1/256 in the plane

	// iteration and escape
	localparam int MAX_ITER     = 255;
	localparam int ESCAPE_LIMIT = 8192; // 4.0

	// frame buffer and palette
	localparam logic [31:0] FB_BASE     = 32'h0000_0000;
	localparam logic [31:0] COLOR_BLACK = 32'hFF00_0000; // inside the set

	typedef logic signed [WIDTH-1:0] fixed_t;
	typedef logic [7:0] iter_t;

	typedef struct packed {
		fixed_t re;
		fixed_t im;
	} complex_t;

	typedef struct packed {
		logic [COORD_BITS-1:0] x;
		logic [COORD_BITS-1:0] y;
	} pixel_t;

	// one finished pixel for the memory controller
	typedef struct packed {
		logic [31:0] addr;  // byte address
		logic [31:0] color; // ARGB
	} result_t;

endpackage

/* hdl/iter_counter.sv */
`timescale 1ns/1ps

module iter_counter (
	input  logic             tb_clk,
	input  logic             rst,
	input  logic             clear,
	input  logic             step,
	output julia_pkg::iter_t count,
	output logic             at_limit
);

	import julia_pkg::*;

	always_ff @(posedge tb_clk) begin
		if (rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (step) begin
			count <= count + iter_t'(1);
		end
	end

	assign at_limit = (count == iter_t'(MAX_ITER));

	// the control FSM must stop stepping at the limit, else count wraps
	a_no_step_at_limit: assert property (@(posedge tb_clk) disable iff (rst)
		!(step && at_limit));

endmodule

/* hdl/jw_control.sv */
`timescale 1ns/1ps

module jw_control (
	input  logic tb_clk,
	input  logic rst,
	input  logic start,
	input  logic mc_busy,
	input  logic escaped,
	input  logic at_limit,
	output logic ready,
	output logic done,
	output logic load,
	output logic step,
	output logic capture
);

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		ITERATE = 2'd1,
		HOLD    = 2'd2
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   finished;

	// stop on escape or when the count runs out
	assign finished = escaped | at_limit;

	always_ff @(posedge tb_clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = ITERATE;
				end
			end
			ITERATE: begin
				if (finished) begin
					state_nxt = HOLD; // capture happens on this edge
				end
			end
			HOLD: begin
				if (!mc_busy) begin
					state_nxt = IDLE; // hand-off to memory controller
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	assign ready   = (state == IDLE);
	assign done    = (state == HOLD);
	assign load    = ready & start; // pixel and c sampled on this edge
	assign step    = (state == ITERATE) & ~finished;
	assign capture = (state == ITERATE) & finished;

	a_ready_done_excl: assert property (@(posedge tb_clk) disable iff (rst)
		!(ready && done));

endmodule

/* hdl/complex_iterator.sv */
`timescale 1ns/1ps

module complex_iterator (
	input  logic                tb_clk,
	input  logic                rst,
	input  logic                load,
	input  logic                step,
	input  julia_pkg::pixel_t   pixel,
	input  julia_pkg::complex_t c,
	output logic                escaped
);

	import julia_pkg::*;

	complex_t z_q;   // current z
	complex_t c_q;   // constant for this pixel
	complex_t z0;    // mapped start value
	complex_t z_nxt;

	fixed_t off_x;
	fixed_t off_y;
	fixed_t z_re;
	fixed_t z_im;
	fixed_t c_re;
	fixed_t c_im;

	logic signed [PROD_W-1:0] rr_full;
	logic signed [PROD_W-1:0] ii_full;
	logic signed [PROD_W-1:0] ri_full;
	logic signed [PROD_W-1:0] rr;
	logic signed [PROD_W-1:0] ii;
	logic signed [PROD_W-1:0] ri;
	logic signed [PROD_W:0]   mag;    // |z|^2, one guard bit
	logic signed [PROD_W:0]   sum_re;
	logic signed [PROD_W:0]   sum_im;

	// pixel offset from screen center
	assign off_x = fixed_t'(pixel.x) - fixed_t'(CENTER_X);
	assign off_y = fixed_t'(CENTER_Y) - fixed_t'(pixel.y); // y axis points up

	always_comb begin
		z0.re = off_x <<< MAP_SHIFT;
		z0.im = off_y <<< MAP_SHIFT;
	end

	assign z_re = z_q.re;
	assign z_im = z_q.im;
	assign c_re = c_q.re;
	assign c_im = c_q.im;

	// full width products, then back to Q11.11
	always_comb begin
		rr_full = PROD_W'(z_re) * PROD_W'(z_re);
		ii_full = PROD_W'(z_im) * PROD_W'(z_im);
		ri_full = PROD_W'(z_re) * PROD_W'(z_im);
		rr      = rr_full >>> FRAC;
		ii      = ii_full >>> FRAC;
		ri      = ri_full >>> FRAC;
	end

	assign mag     = (PROD_W+1)'(rr) + (PROD_W+1)'(ii);
	assign escaped = (mag > ESCAPE_LIMIT); // valid in the same cycle as z_q

	always_comb begin
		sum_re   = (PROD_W+1)'(rr) - (PROD_W+1)'(ii) + (PROD_W+1)'(c_re);
		sum_im   = ((PROD_W+1)'(ri) <<< 1) + (PROD_W+1)'(c_im);
		// truncated to WIDTH bits so overflow wraps
		z_nxt.re = sum_re[WIDTH-1:0];
		z_nxt.im = sum_im[WIDTH-1:0];
	end

	always_ff @(posedge tb_clk) begin
		if (rst) begin
			z_q <= '0;
			c_q <= '0;
		end else if (load) begin
			z_q <= z0;
			c_q <= c;
		end else if (step) begin
			z_q <= z_nxt;
		end
	end

endmodule

/* hdl/pixel_result.sv */
`timescale 1ns/1ps

module pixel_result (
	input  logic               tb_clk,
	input  logic               rst,
	input  logic               load,
	input  logic               capture,
	input  julia_pkg::pixel_t  pixel,
	input  julia_pkg::iter_t   count,
	output julia_pkg::result_t result
);

	import julia_pkg::*;

	pixel_t      pix_q;
	logic [31:0] pix_index;
	logic [7:0]  green;
	result_t     result_nxt;

	// pixel held for the whole iteration
	always_ff @(posedge tb_clk) begin
		if (load) begin
			pix_q <= pixel;
		end
	end

	// row major with four bytes per pixel
	assign pix_index = 32'(pix_q.y) * 32'(SCREEN_W) + 32'(pix_q.x);
	assign green     = {count[4:0], count[7:5]}; // rotate left 3

	always_comb begin
		result_nxt.addr = FB_BASE + (pix_index << 2);
		if (count == iter_t'(MAX_ITER)) begin
			result_nxt.color = COLOR_BLACK;
		end else begin
			result_nxt.color = {8'hFF, count, green, 8'hFF - count};
		end
	end

	always_ff @(posedge tb_clk) begin
		if (rst) begin
			result <= '0;
		end else if (capture) begin
			result <= result_nxt;
		end
	end

	// output must not move while the memory controller may be reading it
	a_result_stable: assert property (@(posedge tb_clk) disable iff (rst)
		!capture |=> $stable(result));

endmodule

/* hdl/julia_worker.sv */
`timescale 1ns/1ps

module julia_worker (
	input  logic               tb_clk,
	input  logic               rst,
	input  logic               start,
	input  julia_pkg::pixel_t  pixel,
	input  julia_pkg::complex_t c,
	input  logic               mc_busy,
	output logic               ready,
	output logic               done,
	output julia_pkg::result_t result
);

	import julia_pkg::*;

	logic  load;
	logic  step;
	logic  capture;
	logic  escaped;
	logic  at_limit;
	iter_t count;

	// sequencing and external handshake
	jw_control u_control (
		.tb_clk   (tb_clk),
		.rst      (rst),
		.start    (start),
		.mc_busy  (mc_busy),
		.escaped  (escaped),
		.at_limit (at_limit),
		.ready    (ready),
		.done     (done),
		.load     (load),
		.step     (step),
		.capture  (capture)
	);

	iter_counter u_counter (
		.tb_clk   (tb_clk),
		.rst      (rst),
		.clear    (load), // fresh count per pixel
		.step     (step),
		.count    (count),
		.at_limit (at_limit)
	);

	// z = z^2 + c datapath
	complex_iterator u_iterator (
		.tb_clk  (tb_clk),
		.rst     (rst),
		.load    (load),
		.step    (step),
		.pixel   (pixel),
		.c       (c),
		.escaped (escaped)
	);

	pixel_result u_result (
		.tb_clk  (tb_clk),
		.rst     (rst),
		.load    (load),
		.capture (capture),
		.pixel   (pixel),
		.count   (count),
		.result  (result)
	);

endmodule

/* tests/julia_ref_model.svh */
`ifndef JULIA_REF_MODEL_SVH
`define JULIA_REF_MODEL_SVH

// golden model of one pixel in 64 bit arithmetic

function automatic complex_t map_pixel(input pixel_t p);
	complex_t z;
	longint   dx;
	longint   dy;
	dx = longint'(p.x) - CENTER_X;
	dy = CENTER_Y - longint'(p.y); // screen rows grow downward
	z.re = fixed_t'(dx * (1 << MAP_SHIFT));
	z.im = fixed_t'(dy * (1 << MAP_SHIFT));
	return z;
endfunction

// product of two Q11.11 values scaled back by the fraction bits
function automatic longint scaled_product(input fixed_t a, input fixed_t b);
	longint la;
	longint lb;
	la = a;
	lb = b;
	return (la * lb) >>> FRAC;
endfunction

function automatic bit has_escaped(input complex_t z);
	return (scaled_product(z.re, z.re) + scaled_product(z.im, z.im)) > ESCAPE_LIMIT;
endfunction

function automatic complex_t z_squared_plus_c(input complex_t z, input complex_t cv);
	complex_t n;
	longint   c_re;
	longint   c_im;
	c_re = cv.re;
	c_im = cv.im;
	n.re = fixed_t'(scaled_product(z.re, z.re) - scaled_product(z.im, z.im) + c_re); // wraps
	n.im = fixed_t'(2 * scaled_product(z.re, z.im) + c_im);
	return n;
endfunction

function automatic int iteration_count(input pixel_t p, input complex_t cv);
	complex_t z;
	int       n;
	z = map_pixel(p);
	n = 0;
	while (n < MAX_ITER && !has_escaped(z)) begin
		z = z_squared_plus_c(z, cv);
		n++;
	end
	return n;
endfunction

function automatic logic [31:0] palette_color(input int n);
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	if (n == MAX_ITER) begin
		return 32'hFF00_0000; // never escaped
	end
	red   = 8'(n);
	green = 8'(((n << 3) | (n >> 5)) & 255);
	blue  = 8'(255 - n);
	return {8'hFF, red, green, blue};
endfunction

function automatic logic [31:0] pixel_address(input pixel_t p);
	return FB_BASE + 32'((int'(p.y) * SCREEN_W + int'(p.x)) * 4);
endfunction

function automatic result_t expected_result(input pixel_t p, input complex_t cv);
	result_t r;
	r.addr  = pixel_address(p);
	r.color = palette_color(iteration_count(p, cv));
	return r;
endfunction

`endif

/* tests/tb_julia_worker.sv */
`timescale 1ns/1ps

module tb_julia_worker;

	import julia_pkg::*;

	`include "julia_ref_model.svh"

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 8;
	localparam int DRIVE_DELAY     = 1;
	localparam int REQ_CYCLES      = MAX_ITER + 20; // one request with back-pressure
	localparam int WATCHDOG_CYCLES = 40 * REQ_CYCLES + RESET_CYCLES;

	logic        tb_clk;
	logic        rst;
	logic        start;
	pixel_t      pixel;
	complex_t    c;
	logic        mc_busy;
	logic        ready;
	logic        done;
	result_t     result;
	logic [31:0] rng_state;

	julia_worker UUT (
		.tb_clk  (tb_clk),
		.rst     (rst),
		.start   (start),
		.pixel   (pixel),
		.c       (c),
		.mc_busy (mc_busy),
		.ready   (ready),
		.done    (done),
		.result  (result)
	);

	initial begin
		tb_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tb_clk = ~tb_clk;
	end

	task automatic end_with_failure();
		$display("tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_value_error(input string msg);
		$display("[ERROR] t=%0t %s", $time, msg);
		end_with_failure();
	endtask

	task automatic check_result(input result_t got, input result_t exp, input string what);
		if (got !== exp) begin
			report_value_error($sformatf("%s: addr %h color %h, expected addr %h color %h",
				what, got.addr, got.color, exp.addr, exp.color));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_value_error($sformatf("%s: got %b, expected %b", what, got, exp));
		end
	endtask

	task automatic compare_latency(input int got, input int exp, input string what);
		if (got != exp) begin
			report_value_error($sformatf("%s: latency %0d, expected %0d", what, got, exp));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic rand_word(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// one clock, then step past the edge
	task automatic next_cycle();
		@(posedge tb_clk);
		#(DRIVE_DELAY);
	endtask

	task automatic issue_start(input pixel_t p, input complex_t cv);
		check_flag(ready, 1'b1, "ready before start");
		start = 1'b1;
		pixel = p;
		c     = cv;
		next_cycle(); // request sampled on this edge
		start = 1'b0;
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		while (done !== 1'b1) begin
			if (cycles > REQ_CYCLES) begin
				$display("timeout: worker did not raise done within %0d cycles", REQ_CYCLES);
				end_with_failure();
			end
			next_cycle();
			cycles++;
		end
	endtask

	// hand-off with mc_busy low
	task automatic release_result(input string what);
		mc_busy = 1'b0;
		next_cycle();
		check_flag(done, 1'b0, {what, " done after hand-off"});
		check_flag(ready, 1'b1, {what, " ready after hand-off"});
	endtask

	task automatic process_pixel(input pixel_t p, input complex_t cv, input result_t exp,
		input string what);
		int cycles;
		issue_start(p, cv);
		wait_done(cycles);
		compare_latency(cycles + 1, iteration_count(p, cv) + 2, what); // counts the load cycle
		check_flag(ready, 1'b0, {what, " ready with done"});
		check_result(result, exp, what);
		release_result(what);
	endtask

	task automatic flags_after_reset();
		check_flag(ready, 1'b1, "ready after reset");
		check_flag(done, 1'b0, "done after reset");
	endtask

	task automatic center_pixel_black();
		pixel_t   p;
		complex_t cv;
		result_t  exp;
		p   = '{x: 10'd320, y: 10'd240};
		cv  = '{re: fixed_t'(0), im: fixed_t'(0)};
		exp = '{addr: pixel_address(p), color: 32'hFF00_0000}; // z stays at 0
		process_pixel(p, cv, exp, "center pixel");
	endtask

	task automatic corner_pixel();
		pixel_t   p;
		complex_t cv;
		p  = '{x: 10'd0, y: 10'd0};
		cv = '{re: fixed_t'(-1024), im: fixed_t'(1024)}; // -0.5 + 0.5i
		process_pixel(p, cv, expected_result(p, cv), "corner pixel");
	endtask

	task automatic back_pressure_hold();
		pixel_t      p;
		complex_t    cv;
		result_t     held;
		logic [31:0] r;
		int          cycles;
		int          hold;
		p  = '{x: 10'd400, y: 10'd180};
		cv = '{re: fixed_t'(-1638), im: fixed_t'(320)};
		rand_word(r);
		hold    = int'(r % 32'd20) + 1;
		mc_busy = 1'b1;
		issue_start(p, cv);
		wait_done(cycles);
		check_result(result, expected_result(p, cv), "back-pressure result");
		held = result;
		for (int i = 0; i < hold; i++) begin
			next_cycle();
			check_flag(done, 1'b1, "done while busy");
			check_flag(ready, 1'b0, "ready while busy");
			check_result(result, held, "result while busy");
		end
		release_result("back-pressure");
	endtask

	task automatic stray_start_ignored();
		pixel_t   p;
		complex_t cv;
		result_t  exp;
		int       cycles;
		p   = '{x: 10'd300, y: 10'd200};
		cv  = '{re: fixed_t'(0), im: fixed_t'(0)};
		exp = expected_result(p, cv);
		issue_start(p, cv);
		repeat (3) next_cycle();
		check_flag(ready, 1'b0, "ready while iterating");
		start = 1'b1; // stray request mid-iteration
		pixel = '{x: 10'd5, y: 10'd7};
		c     = '{re: fixed_t'(1024), im: fixed_t'(-512)};
		next_cycle();
		start = 1'b0;
		wait_done(cycles);
		check_result(result, exp, "stray start");
		release_result("stray start");
	endtask

	task automatic random_pixels(input int n);
		pixel_t      p;
		complex_t    cv;
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			rand_word(r);
			p.x = 10'(r % 32'd640);
			rand_word(r);
			p.y = 10'(r % 32'd480);
			rand_word(r);
			cv.re = fixed_t'(int'(r % 32'd4097) - 2048); // within +-1.0
			rand_word(r);
			cv.im = fixed_t'(int'(r % 32'd4097) - 2048);
			process_pixel(p, cv, expected_result(p, cv), $sformatf("random pixel %0d", i));
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge tb_clk);
		$display("timeout: the run took longer than %0d clock cycles", WATCHDOG_CYCLES);
		end_with_failure();
	end

	initial begin
		rst       = 1'b1;
		start     = 1'b0;
		pixel     = '0;
		c         = '0;
		mc_busy   = 1'b0;
		rng_state = 32'h6f7da2d5;
		repeat (RESET_CYCLES) @(posedge tb_clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		flags_after_reset();
		center_pixel_black();
		corner_pixel();
		back_pressure_hold();
		stray_start_ignored();
		random_pixels(30);
		$display("all tests passed");
		$finish;
	end

endmodule

/* julia_worker.f */
+incdir+tests
hdl/julia_pkg.sv
hdl/iter_counter.sv
hdl/jw_control.sv
hdl/complex_iterator.sv
hdl/pixel_result.sv
hdl/julia_worker.sv
tests/tb_julia_worker.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the Julia worker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f julia_worker.f \
	--top-module tb_julia_worker -o tb_julia_worker || exit 1
./obj_dir/tb_julia_worker > sim.log 2>&1
cat sim.log
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
